// ==== logic/cordic_pkg.sv ====
package cordic_pkg;

    // input angle and output codes, signed Q1.6
    localparam int ANGLE_W = 8;
    localparam int FRAC_IO = 6;

    // rotation datapath, signed Q1.12
    localparam int WORK_W    = 14;
    localparam int FRAC_WORK = 12;

    // longest chain the arctangent table supports
    localparam int MAX_STAGES = 14;

    typedef logic signed [WORK_W-1:0]  work_t;
    typedef logic signed [ANGLE_W-1:0] io_t;

    // 1/K = 0.60725 in Q1.12, so the chain ends with unit magnitude
    localparam work_t CORDIC_GAIN_INIT = work_t'(2487);

    // atan(2^-idx) in Q1.12 units, rounded to nearest
    function automatic work_t atan_code(input int idx);
        work_t code;
        case (idx)
            0: begin
                code = work_t'(3217);
            end
            1: begin
                code = work_t'(1899);
            end
            2: begin
                code = work_t'(1003);
            end
            3: begin
                code = work_t'(509);
            end
            4: begin
                code = work_t'(256);
            end
            5: begin
                code = work_t'(128);
            end
            6: begin
                code = work_t'(64);
            end
            7: begin
                code = work_t'(32);
            end
            8: begin
                code = work_t'(16);
            end
            9: begin
                code = work_t'(8);
            end
            10: begin
                code = work_t'(4);
            end
            11: begin
                code = work_t'(2);
            end
            // from here on the angle sits at or below half an LSB,
            // held at one LSB so every stage still moves z
            default: begin
                code = work_t'(1);
            end
        endcase
        return code;
    endfunction

endpackage

// ==== logic/angle_fold.sv ====
`timescale 1ns/1ps

module angle_fold import cordic_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  io_t   angle,
    output work_t x,
    output work_t y,
    output work_t z,
    output logic  neg
);

    // largest magnitude the rotation chain can converge on, about 1.56 rad
    localparam int ANGLE_LIMIT = 100;

    logic              angle_neg;
    logic [ANGLE_W-1:0] angle_mag;

    assign angle_neg = angle[ANGLE_W-1];

    // two's complement magnitude
    assign angle_mag = angle_neg ? ANGLE_W'(-angle) : ANGLE_W'(angle);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x   <= '0;
            y   <= '0;
            z   <= '0;
            neg <= 1'b0;
        end else begin
            // start vector already scaled by the chain gain
            x   <= CORDIC_GAIN_INIT;
            y   <= '0;
            // Q1.6 to Q1.12
            z   <= work_t'(angle_mag) <<< (FRAC_WORK - FRAC_IO);
            neg <= angle_neg;
        end
    end

    // stage convergence only holds inside this range
    a_angle_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        (angle <= ANGLE_LIMIT) && (angle >= -ANGLE_LIMIT)
    ) else $error("angle %0d outside +/-%0d", angle, ANGLE_LIMIT);

endmodule

// ==== logic/cordic_stage.sv ====
`timescale 1ns/1ps

module cordic_stage import cordic_pkg::*; #(
    parameter int SHIFT = 0
) (
    input  logic  clk,
    input  logic  rst_n,
    input  work_t x_in,
    input  work_t y_in,
    input  work_t z_in,
    input  logic  neg_in,
    output work_t x_out,
    output work_t y_out,
    output work_t z_out,
    output logic  neg_out
);

    // elementary angle for this stage
    localparam work_t ATAN = atan_code(SHIFT);

    // residual leaving this stage stays within one elementary angle,
    // the bound is kept at twice that for quantisation slack
    localparam int Z_LIMIT = 2 * int'(ATAN);

    logic  rot_neg;
    work_t x_shift;
    work_t y_shift;

    // negative residual means we overshot, so rotate back
    assign rot_neg = z_in[WORK_W-1];

    // arithmetic shifts keep the sign of the partner coordinate
    assign x_shift = x_in >>> SHIFT;
    assign y_shift = y_in >>> SHIFT;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x_out   <= '0;
            y_out   <= '0;
            z_out   <= '0;
            neg_out <= 1'b0;
        end else begin
            if (rot_neg) begin
                // clockwise
                x_out <= x_in + y_shift;
                y_out <= y_in - x_shift;
                z_out <= z_in + ATAN;
            end else begin
                // counter clockwise
                x_out <= x_in - y_shift;
                y_out <= y_in + x_shift;
                z_out <= z_in - ATAN;
            end
            // sign of the original angle rides with its own data
            neg_out <= neg_in;
        end
    end

    // depends on the input range check and on every stage upstream
    a_residual_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        (z_out < Z_LIMIT) && (z_out > -Z_LIMIT)
    ) else $error("stage %0d residual %0d beyond %0d", SHIFT, z_out, Z_LIMIT);

endmodule

// ==== logic/result_format.sv ====
`timescale 1ns/1ps

module result_format import cordic_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  work_t x,
    input  work_t y,
    input  logic  neg,
    output io_t   sine,
    output io_t   cosine
);

    // bits dropped going from Q1.12 to Q1.6
    localparam int DROP = FRAC_WORK - FRAC_IO;

    io_t sine_code;
    io_t cosine_code;
    io_t sine_signed;

    // sign, integer bit and top six fraction bits, rest truncated
    assign sine_code   = y[DROP +: ANGLE_W];
    assign cosine_code = x[DROP +: ANGLE_W];

    // sin(-a) = -sin(a), cosine is even so it is left alone
    always_comb begin
        if (neg) begin
            sine_signed = -sine_code;
        end else begin
            sine_signed = sine_code;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sine   <= '0;
            cosine <= '0;
        end else begin
            sine   <= sine_signed;
            cosine <= cosine_code;
        end
    end

    // angles stay inside +/-pi/2, so at most one LSB of truncation
    // error may take cosine below zero
    a_cosine_floor: assert property (
        @(posedge clk) disable iff (!rst_n)
        cosine >= -1
    ) else $error("cosine %0d below -1 LSB", cosine);

endmodule

// ==== logic/cordic_top.sv ====
`timescale 1ns/1ps

module cordic_top import cordic_pkg::*; #(
    parameter int STAGES = 12
) (
    input  logic clk,
    input  logic rst_n,
    input  io_t  angle,
    output io_t  sine,
    output io_t  cosine
);

    // index k is the input of stage k, index STAGES feeds the formatter
    work_t x_chain   [0:STAGES];
    work_t y_chain   [0:STAGES];
    work_t z_chain   [0:STAGES-1];
    logic  neg_chain [0:STAGES];

    if (STAGES < 8 || STAGES > MAX_STAGES) begin : g_bad_stages
        $error("STAGES = %0d, must lie in 8..%0d", STAGES, MAX_STAGES);
    end

    angle_fold angle_fold_i (
        .clk   (clk),
        .rst_n (rst_n),
        .angle (angle),
        .x     (x_chain[0]),
        .y     (y_chain[0]),
        .z     (z_chain[0]),
        .neg   (neg_chain[0])
    );

    // stage k shifts by k and uses atan(2^-k)
    for (genvar k = 0; k < STAGES; k++) begin : g_stage
        if (k < STAGES - 1) begin : g_mid
            cordic_stage #(.SHIFT(k)) cordic_stage_i (
                .clk     (clk),
                .rst_n   (rst_n),
                .x_in    (x_chain[k]),
                .y_in    (y_chain[k]),
                .z_in    (z_chain[k]),
                .neg_in  (neg_chain[k]),
                .x_out   (x_chain[k+1]),
                .y_out   (y_chain[k+1]),
                .z_out   (z_chain[k+1]),
                .neg_out (neg_chain[k+1])
            );
        end else begin : g_last
            // final residual has no consumer
            cordic_stage #(.SHIFT(k)) cordic_stage_i (
                .clk     (clk),
                .rst_n   (rst_n),
                .x_in    (x_chain[k]),
                .y_in    (y_chain[k]),
                .z_in    (z_chain[k]),
                .neg_in  (neg_chain[k]),
                .x_out   (x_chain[k+1]),
                .y_out   (y_chain[k+1]),
                .z_out   (),
                .neg_out (neg_chain[k+1])
            );
        end
    end

    result_format result_format_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .x      (x_chain[STAGES]),
        .y      (y_chain[STAGES]),
        .neg    (neg_chain[STAGES]),
        .sine   (sine),
        .cosine (cosine)
    );

endmodule

// ==== testbench/cordic_vectors.svh ====
`ifndef CORDIC_VECTORS_SVH
`define CORDIC_VECTORS_SVH

// columns: angle in Q1.6 radians, then sin and cos as Q1.6 codes
// truncated toward zero
localparam int VEC_COUNT = 17;

localparam int VEC_ANGLE [VEC_COUNT] = '{
    0, 1, -1, 8, -8, 16, 32, -32, 45,
    50, -50, 67, -67, -80, 90, 100, -100
};

localparam int VEC_SINE [VEC_COUNT] = '{
    0, 0, 0, 7, -7, 15, 30, -30, 41,
    45, -45, 55, -55, -60, 63, 63, -63
};

// cosine is even, so mirrored angles share a code
localparam int VEC_COSINE [VEC_COUNT] = '{
    64, 63, 63, 63, 63, 62, 56, 56, 48,
    45, 45, 32, 32, 20, 10, 0, 0
};

`endif

// ==== testbench/cordic_tb.sv ====
`timescale 1ns/1ps

module cordic_tb import cordic_pkg::*; ();

    // falling edges from driving an angle to seeing its result
    localparam int LATENCY = 14;
    localparam int TOL     = 2;
    localparam int PAIRS   = 20;
    localparam int STREAM  = 200;

    localparam int TAG_NONE   = 0;
    localparam int TAG_VALUE  = 1;
    localparam int TAG_PAIR_A = 2;
    localparam int TAG_PAIR_B = 3;

    `include "cordic_vectors.svh"

    // every test plus the drain that follows it
    localparam int RUN_CYCLES = 2 + LATENCY + (VEC_COUNT + LATENCY) + (2 * LATENCY + 1)
                                + (2 * PAIRS + LATENCY) + (STREAM + LATENCY);
    localparam int CYCLE_LIMIT = 2 * RUN_CYCLES + LATENCY;

    typedef struct packed {
        int ang;
        int sin_code;
        int cos_code;
        int tag;
    } entry_t;

    logic   clk = 1'b0;
    logic   rst_n;
    io_t    angle;
    io_t    sine;
    io_t    cosine;

    integer seed = 32'h573e9c82;
    int     cycle_count = 0;
    int     test_checks = 0;
    int     test_errors = 0;
    int     total_checks = 0;
    int     total_errors = 0;
    int     tests_run = 0;
    integer seen_sine;
    integer seen_cosine;
    int     pair_sine;
    int     pair_cosine;
    entry_t pending[$];

    cordic_top cordic_top_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .angle  (angle),
        .sine   (sine),
        .cosine (cosine)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // Q1.6 codes in and out with truncation toward zero
    function automatic int sine_ref(input int a);
        return $rtoi($sin($itor(a) / 64.0) * 64.0);
    endfunction

    function automatic int cosine_ref(input int a);
        return $rtoi($cos($itor(a) / 64.0) * 64.0);
    endfunction

    // uniform over -100..100
    function automatic int random_angle();
        int r;
        r = $random(seed);
        return ((r % 201) + 201) % 201 - 100;
    endfunction

    task automatic check_code(input string name, input string where,
                              input integer got, input int exp, input int tol);
        integer diff;
        diff = got - exp;
        test_checks++;
        assert ((diff <= tol) && (diff >= -tol)) else begin
            $display("error: %s %s expected %h got %h", name, where, io_t'(exp), io_t'(got));
            test_errors++;
        end
    endtask

    // samples, checks the entry due now and drives the next angle
    task automatic step(input int ang, input int exp_sine, input int exp_cosine, input int tag);
        entry_t head;
        string  where;
        seen_sine   = sine;
        seen_cosine = cosine;
        if (pending.size() == LATENCY) begin
            head  = pending.pop_front();
            where = $sformatf("for angle %0d", head.ang);
            if (head.tag != TAG_NONE) begin
                check_code("sine", where, seen_sine, head.sin_code, TOL);
                check_code("cosine", where, seen_cosine, head.cos_code, TOL);
            end
            if (head.tag == TAG_PAIR_A) begin
                pair_sine   = seen_sine;
                pair_cosine = seen_cosine;
            end
            if (head.tag == TAG_PAIR_B) begin
                check_code("sine", {where, " vs mirror"}, seen_sine, -pair_sine, 0);
                check_code("cosine", {where, " vs mirror"}, seen_cosine, pair_cosine, 0);
            end
        end
        angle = io_t'(ang);
        pending.push_back(entry_t'{ang, exp_sine, exp_cosine, tag});
        @(negedge clk);
    endtask

    task automatic drain();
        repeat (LATENCY) begin
            step(0, 0, 64, TAG_NONE);
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
        total_checks += test_checks;
        total_errors += test_errors;
        tests_run++;
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        int a;
        rst_n = 1'b0;
        angle = '0;

        repeat (2) begin
            @(negedge clk);
            check_code("sine", "in reset", sine, 0, 0);
            check_code("cosine", "in reset", cosine, 0, 0);
        end
        rst_n = 1'b1;
        // outputs stay cleared until the first sampled angle arrives
        for (int k = 0; k < LATENCY; k++) begin
            step(0, 0, 64, TAG_NONE);
            check_code("sine", $sformatf("%0d cycles after reset", k), seen_sine, 0, 0);
            check_code("cosine", $sformatf("%0d cycles after reset", k), seen_cosine, 0, 0);
        end
        finish_test("reset");

        for (int i = 0; i < VEC_COUNT; i++) begin
            step(VEC_ANGLE[i], VEC_SINE[i], VEC_COSINE[i], TAG_VALUE);
        end
        drain();
        finish_test("table");

        // pipeline holds only zero angles here
        step(50, sine_ref(50), cosine_ref(50), TAG_VALUE);
        for (int k = 1; k <= LATENCY; k++) begin
            step(0, 0, 64, TAG_NONE);
            if (k < LATENCY) begin
                check_code("sine", $sformatf("%0d cycles after angle 50", k), seen_sine, 0, 0);
            end else begin
                test_checks++;
                assert (seen_sine != 0) else begin
                    $display("sine still zero %0d cycles after angle 50 was applied", k);
                    test_errors++;
                end
            end
        end
        drain();
        finish_test("latency");

        for (int p = 0; p < PAIRS; p++) begin
            a = random_angle();
            step(a, sine_ref(a), cosine_ref(a), TAG_PAIR_A);
            step(-a, sine_ref(-a), cosine_ref(-a), TAG_PAIR_B);
        end
        drain();
        finish_test("symmetry");

        for (int s = 0; s < STREAM; s++) begin
            a = random_angle();
            step(a, sine_ref(a), cosine_ref(a), TAG_VALUE);
        end
        drain();
        finish_test("streaming");

        $display("summary: %0d tests, %0d checks, %0d errors",
                 tests_run, total_checks, total_errors);
        if (total_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+testbench
logic/cordic_pkg.sv
logic/angle_fold.sv
logic/cordic_stage.sv
logic/result_format.sv
logic/cordic_top.sv
testbench/cordic_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the CORDIC testbench with Verilator and runs it, the log decides the result

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module cordic_tb -f tb.f \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/Vcordic_tb > sim.log 2>&1 || true
cat sim.log

grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TESTBENCH PASSED" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "simulation passed"
